// File: logic/dbg_bus_pkg.sv
// Wishbone request and response structs, register address map, identifier value
package dbg_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus structs

  // Request from the debug host, one word per access
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  // Response back to the host
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map, word indices

  localparam logic [1:0] REG_CTRL   = 2'd0;
  localparam logic [1:0] REG_STATUS = 2'd1;
  // Write 1 to bit 0 clears the breakpoint flag
  localparam logic [1:0] REG_BPCLR  = 2'd2;
  localparam logic [1:0] REG_ID     = 2'd3;

  // Value returned by REG_ID
  localparam logic [31:0] DBG_ID = 32'h0D1B_0001;

endpackage

// File: logic/dbg_cpu_ctrl.sv
// Execute stage with stall/reset controls, sticky breakpoint flag and status word
`timescale 1ns/1ps

module dbg_cpu_ctrl (
  input  logic                       CLKA,
  input  logic                       RST,
  input  dbg_cpu_pkg::dbg_cmd_t      cmd,
  input  logic                       cpu_bp,
  output logic [31:0]                ctrl_q,
  output dbg_cpu_pkg::cpu_status_t   status,
  output logic                       cpu_stall,
  output logic                       cpu_rst
);

  import dbg_bus_pkg::*;
  import dbg_cpu_pkg::*;

  logic stall_req;
  logic rst_req;
  logic bp_hit;
  logic wr_cmd;
  logic wr_ctrl;
  logic wr_bpclr;

  ////////////////////////////////////////////////////////////////////////////
  // Write decode

  assign wr_cmd   = cmd.valid && (cmd.op == OP_WRITE);
  assign wr_ctrl  = wr_cmd && (cmd.adr == REG_CTRL);
  // Only bit 0 of the data clears the flag
  assign wr_bpclr = wr_cmd && (cmd.adr == REG_BPCLR) && cmd.dat[0];

  // CTRL register, bits 1:0 only
  always_ff @(posedge CLKA or posedge RST) begin
    if (RST) begin
      stall_req <= 1'b0;
      rst_req   <= 1'b0;
    end else if (wr_ctrl) begin
      stall_req <= cmd.dat[0];
      rst_req   <= cmd.dat[1];
    end
  end

  // Sticky breakpoint, set beats clear
  always_ff @(posedge CLKA or posedge RST) begin
    if (RST) begin
      bp_hit <= 1'b0;
    end else if (cpu_bp) begin
      bp_hit <= 1'b1;
    end else if (wr_bpclr) begin
      bp_hit <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs to the CPU and the status word

  // A breakpoint stalls the core on its own
  assign cpu_stall = stall_req | bp_hit;
  assign cpu_rst   = rst_req;

  // Upper bits read back as zero
  assign ctrl_q = {30'd0, rst_req, stall_req};

  assign status = '{
    bp_hit:    bp_hit,
    cpu_rst:   rst_req,
    cpu_stall: cpu_stall,
    running:   !(cpu_stall || rst_req)
  };

  // Breakpoint pulse lands as a stall on the next cycle, even against a clear
  a_bp_stalls: assert property (@(posedge CLKA) disable iff (RST)
    cpu_bp |=> (bp_hit && cpu_stall));

endmodule

// File: logic/dbg_cpu_if_top.sv
// Top level of the CPU debug control block with bus path and status crossing
`timescale 1ns/1ps

module dbg_cpu_if_top (
  input  logic                       CLKA,
  input  logic                       CLKB,
  input  logic                       RST,
  input  dbg_bus_pkg::wb_req_t       wb_req,
  output dbg_bus_pkg::wb_rsp_t       wb_rsp,
  input  logic                       cpu_bp,
  output logic                       cpu_stall,
  output logic                       cpu_rst,
  output dbg_cpu_pkg::cpu_status_t   tck_status
);

  import dbg_cpu_pkg::*;

  dbg_cmd_t    cmd;
  logic [31:0] ctrl_q;
  cpu_status_t status;

  ////////////////////////////////////////////////////////////////////////////
  // Bus path, CLKA

  // Request sampling
  dbg_wb_decode decode_inst (
    .CLKA   (CLKA),
    .RST    (RST),
    .wb_req (wb_req),
    .cmd    (cmd)
  );

  // Register state and CPU controls
  dbg_cpu_ctrl ctrl_inst (
    .CLKA      (CLKA),
    .RST       (RST),
    .cmd       (cmd),
    .cpu_bp    (cpu_bp),
    .ctrl_q    (ctrl_q),
    .status    (status),
    .cpu_stall (cpu_stall),
    .cpu_rst   (cpu_rst)
  );

  // Ack and read data
  dbg_wb_result result_inst (
    .cmd    (cmd),
    .ctrl_q (ctrl_q),
    .status (status),
    .wb_rsp (wb_rsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Status into the tap clock domain

  dbg_syncreg syncreg_inst (
    .CLKA     (CLKA),
    .CLKB     (CLKB),
    .RST      (RST),
    .data_in  (status),
    .data_out (tck_status)
  );

endmodule

// File: logic/dbg_cpu_pkg.sv
// Debug command struct, command opcodes, CPU status struct
package dbg_cpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Commands from the bus decode stage

  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2
  } dbg_op_e;

  // One-cycle command, only meaningful while valid is high
  typedef struct packed {
    dbg_op_e     op;
    logic [1:0]  adr;
    logic [31:0] dat;
    logic        valid;
  } dbg_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // CPU state summary, top bit first

  typedef struct packed {
    logic bp_hit;
    logic cpu_rst;
    logic cpu_stall;
    logic running;
  } cpu_status_t;

endpackage

// File: logic/dbg_syncflop.sv
// Toggle synchronizer with sticky change flag in the destination domain
`timescale 1ns/1ps

module dbg_syncflop (
  input  logic CLKA,
  input  logic RST,
  input  logic toggle_in,
  input  logic clr,
  output logic flag
);

  logic sync1;
  logic sync2;
  logic hist;
  logic change;

  // Two-flop synchronizer plus one flop of history
  always_ff @(posedge CLKA or posedge RST) begin
    if (RST) begin
      sync1 <= 1'b0;
      sync2 <= 1'b0;
      hist  <= 1'b0;
    end else begin
      sync1 <= toggle_in;
      sync2 <= sync1;
      hist  <= sync2;
    end
  end

  // Either edge of the source toggle counts as an event
  assign change = sync2 ^ hist;

  // Sticky until the consumer clears it
  always_ff @(posedge CLKA or posedge RST) begin
    if (RST) begin
      flag <= 1'b0;
    end else if (change) begin
      flag <= 1'b1;
    end else if (clr) begin
      flag <= 1'b0;
    end
  end

  // Handshake keeps a new toggle event away from a pending clear
  a_no_rise_on_clr: assert property (@(posedge CLKA) disable iff (RST) clr |=> !flag);

endmodule

// File: logic/dbg_syncreg.sv
// Status register carried from CLKA to CLKB by a strobe/ack toggle handshake
`timescale 1ns/1ps

module dbg_syncreg (
  input  logic                      CLKA,
  input  logic                      CLKB,
  input  logic                      RST,
  input  dbg_cpu_pkg::cpu_status_t  data_in,
  output dbg_cpu_pkg::cpu_status_t  data_out
);

  import dbg_cpu_pkg::*;

  cpu_status_t reg_a;
  cpu_status_t reg_b;
  logic        strobe_toggle;
  logic        ack_toggle;
  logic        strobe_flag;
  logic        ack_flag;
  logic        a_enable;

  ////////////////////////////////////////////////////////////////////////////
  // Source side, CLKA

  // Capture only a new value, and only once the last one was taken
  assign a_enable = (data_in != reg_a) && ack_flag;

  always_ff @(posedge CLKA or posedge RST) begin
    if (RST) begin
      reg_a         <= '0;
      strobe_toggle <= 1'b0;
    end else if (a_enable) begin
      reg_a         <= data_in;
      strobe_toggle <= ~strobe_toggle;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Destination side, CLKB

  // Ack toggle starts at 1 so the first value goes out by itself
  always_ff @(posedge CLKB or posedge RST) begin
    if (RST) begin
      reg_b      <= '0;
      ack_toggle <= 1'b1;
    end else if (strobe_flag) begin
      reg_b      <= reg_a;
      ack_toggle <= ~ack_toggle;
    end
  end

  assign data_out = reg_b;

  // Strobe event into CLKB, consumed on the cycle it shows
  dbg_syncflop strobe_sff (
    .CLKA      (CLKB),
    .RST       (RST),
    .toggle_in (strobe_toggle),
    .clr       (strobe_flag),
    .flag      (strobe_flag)
  );

  // Ack event back into CLKA, held until the next capture
  dbg_syncflop ack_sff (
    .CLKA      (CLKA),
    .RST       (RST),
    .toggle_in (ack_toggle),
    .clr       (a_enable),
    .flag      (ack_flag)
  );

  // Register B only moves on a strobe, so reg_a is stable when sampled
  a_b_on_strobe: assert property (@(posedge CLKB) disable iff (RST)
    !strobe_flag |=> $stable(reg_b));

endmodule

// File: logic/dbg_wb_decode.sv
// Wishbone request sampling into one-cycle debug commands
`timescale 1ns/1ps

module dbg_wb_decode (
  input  logic                    CLKA,
  input  logic                    RST,
  input  dbg_bus_pkg::wb_req_t    wb_req,
  output dbg_cpu_pkg::dbg_cmd_t   cmd
);

  import dbg_cpu_pkg::*;

  logic        req_hit;
  logic        valid_q;
  dbg_op_e     op_q;
  logic [1:0]  adr_q;
  logic [31:0] dat_q;

  // Master still holds stb during the ack cycle, so skip that one
  assign req_hit = wb_req.cyc && wb_req.stb && !valid_q;

  // Control part
  always_ff @(posedge CLKA or posedge RST) begin
    if (RST) begin
      valid_q <= 1'b0;
      op_q    <= OP_NONE;
    end else begin
      valid_q <= req_hit;
      if (req_hit) begin
        op_q <= wb_req.we ? OP_WRITE : OP_READ;
      end else begin
        op_q <= OP_NONE;
      end
    end
  end

  // Address and write data, no reset needed
  always_ff @(posedge CLKA) begin
    if (req_hit) begin
      adr_q <= wb_req.adr;
      dat_q <= wb_req.dat;
    end
  end

  assign cmd = '{op: op_q, adr: adr_q, dat: dat_q, valid: valid_q};

  // One request gives one command
  a_single_cmd: assert property (@(posedge CLKA) disable iff (RST)
    cmd.valid |=> !cmd.valid);

endmodule

// File: logic/dbg_wb_result.sv
// Read-data multiplexer and Wishbone acknowledge
`timescale 1ns/1ps

module dbg_wb_result (
  input  dbg_cpu_pkg::dbg_cmd_t      cmd,
  input  logic [31:0]                ctrl_q,
  input  dbg_cpu_pkg::cpu_status_t   status,
  output dbg_bus_pkg::wb_rsp_t       wb_rsp
);

  import dbg_bus_pkg::*;
  import dbg_cpu_pkg::*;

  logic [31:0] rd_dat;

  // Reads see the current register state, writes return zero
  always_comb begin
    rd_dat = 32'd0;
    if (cmd.op == OP_READ) begin
      case (cmd.adr)
        REG_CTRL:   rd_dat = ctrl_q;
        REG_STATUS: rd_dat = {28'd0, status};
        REG_BPCLR:  rd_dat = 32'd0;
        REG_ID:     rd_dat = DBG_ID;
      endcase
    end
  end

  // Ack for exactly the command cycle
  assign wb_rsp = '{ack: cmd.valid, dat: rd_dat};

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the debug block testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module dbg_cpu_if_tb -f sim.f -o dbg_cpu_if_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/dbg_cpu_if_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: sim.f
logic/dbg_bus_pkg.sv
logic/dbg_cpu_pkg.sv
logic/dbg_syncflop.sv
logic/dbg_syncreg.sv
logic/dbg_wb_decode.sv
logic/dbg_cpu_ctrl.sv
logic/dbg_wb_result.sv
logic/dbg_cpu_if_top.sv
tests/dbg_cpu_if_tb.sv

// File: tests/dbg_cpu_if_tb.sv
// Testbench for the CPU debug control block with LFSR stimulus, reference model and watchdog
`timescale 1ns/1ps

module dbg_cpu_if_tb;

  import dbg_bus_pkg::*;
  import dbg_cpu_pkg::*;

  localparam int CLKA_PER  = 40;
  localparam int CLKB_PER  = 68;
  localparam int RST_CYC   = 16;
  localparam int NUM_ACC   = 300;
  // Directed accesses after the random ones
  localparam int NUM_DIR   = 3;
  localparam int ACK_LIMIT = 4;
  // One status transfer plus a CLKB period of sampling lag
  localparam int XFER_CYC  = (4 * CLKB_PER + 4 * CLKA_PER + CLKB_PER) / CLKA_PER + 1;
  // A transfer may still be in flight when the status goes quiet
  localparam int SETTLE_CYC = 2 * XFER_CYC;
  localparam int WATCHDOG_NS =
    ((NUM_ACC + NUM_DIR) * 4 + (NUM_ACC / 50 + 2) * SETTLE_CYC + RST_CYC + 50) * CLKA_PER;
  localparam logic [31:0] EXP_ID = 32'h0D1B_0001;

  logic        CLKA;
  logic        CLKB;
  logic        RST;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        cpu_bp;
  logic        cpu_stall;
  logic        cpu_rst;
  cpu_status_t tck_status;

  // Reference model state
  logic [1:0]  m_ctrl;
  logic        m_bp;
  logic        pend_wr;
  logic [1:0]  pend_adr;
  logic [31:0] pend_dat;
  // One bit per status value the CPU side has held
  logic [15:0] seen_mask;
  logic [3:0]  tck_bits;
  logic [15:0] lfsr_q;
  int          val_errs;
  int          other_errs;

  dbg_cpu_if_top dbg_cpu_if_top_inst (
    .CLKA       (CLKA),
    .CLKB       (CLKB),
    .RST        (RST),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .cpu_bp     (cpu_bp),
    .cpu_stall  (cpu_stall),
    .cpu_rst    (cpu_rst),
    .tck_status (tck_status)
  );

  always #(CLKA_PER / 2) CLKA = ~CLKA;
  always #(CLKB_PER / 2) CLKB = ~CLKB;

  ////////////////////////////////////////////////////////////////////////////
  // Random bits and model helpers

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // bp_hit, cpu_rst, cpu_stall, running
  function automatic logic [3:0] model_status();
    logic stall;
    stall = m_ctrl[0] | m_bp;
    return {m_bp, m_ctrl[1], stall, ~(stall | m_ctrl[1])};
  endfunction

  function automatic logic [31:0] exp_rdata(input logic [1:0] adr);
    logic [31:0] d;
    case (adr)
      REG_CTRL:   d = {30'd0, m_ctrl};
      REG_STATUS: d = {28'd0, model_status()};
      REG_BPCLR:  d = 32'd0;
      default:    d = EXP_ID;
    endcase
    return d;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Cycle, idle, access and crossing tasks

  // Model update at the rising edge and checks plus drive at the falling one
  task automatic step(input logic allow_bp);
    logic       clr;
    logic [3:0] exp_st;
    @(posedge CLKA);
    clr = 1'b0;
    if (pend_wr) begin
      if (pend_adr == REG_CTRL) begin
        m_ctrl = pend_dat[1:0];
      end
      clr     = (pend_adr == REG_BPCLR) && pend_dat[0];
      pend_wr = 1'b0;
    end
    // Breakpoint beats a clear on the same edge
    if (cpu_bp) begin
      m_bp = 1'b1;
    end else if (clr) begin
      m_bp = 1'b0;
    end
    exp_st = model_status();
    seen_mask[exp_st] = 1'b1;
    @(negedge CLKA);
    assert (cpu_stall == exp_st[1]) else begin
      val_errs++;
      $display("Error: cpu_stall got %h expected %h", cpu_stall, exp_st[1]);
    end
    assert (cpu_rst == exp_st[2]) else begin
      val_errs++;
      $display("Error: cpu_rst got %h expected %h", cpu_rst, exp_st[2]);
    end
    if (allow_bp) begin
      cpu_bp = (take_bits(5) == 32'd0);
    end else begin
      cpu_bp = 1'b0;
    end
  endtask

  task automatic idle(input int n, input logic allow_bp);
    repeat (n) begin
      step(allow_bp);
      assert (!wb_rsp.ack) else begin
        other_errs++;
        $display("ack was raised with no request pending");
      end
    end
  endtask

  task automatic access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                        input logic bp_on_write);
    int          waited;
    logic        got_ack;
    logic [31:0] exp;
    wb_req  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    waited  = 0;
    got_ack = 1'b0;
    while (!got_ack && waited < ACK_LIMIT) begin
      step(1'b1);
      waited++;
      got_ack = wb_rsp.ack;
    end
    assert (got_ack) else begin
      other_errs++;
      $display("no ack within %0d cycles for register %0d", ACK_LIMIT, adr);
    end
    if (got_ack) begin
      assert (waited == 1) else begin
        other_errs++;
        $display("ack came %0d cycles after the request instead of one", waited);
      end
      // Writes return zero and reads see the registers after the sampling edge
      exp = we ? 32'd0 : exp_rdata(adr);
      assert (wb_rsp.dat == exp) else begin
        val_errs++;
        $display("Error: wb_rsp.dat got %h expected %h", wb_rsp.dat, exp);
      end
      pend_wr  = we;
      pend_adr = adr;
      pend_dat = dat;
      // Breakpoint sampled on the edge that applies the write
      if (bp_on_write) begin
        cpu_bp = 1'b1;
      end
    end
    // The master sees ack at the next edge and holds stb until then
    step(1'b1);
    assert (!wb_rsp.ack) else begin
      other_errs++;
      $display("a single request got a second ack");
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    idle(1, 1'b1);
  endtask

  // Hold the status still and the tap side must then show it
  task automatic check_crossing(input int cycles);
    logic [3:0] exp_st;
    idle(cycles, 1'b0);
    exp_st = model_status();
    assert (tck_status == exp_st) else begin
      val_errs++;
      $display("Error: tck_status got %h expected %h", tck_status, exp_st);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tap side monitor

  always @(negedge CLKB) begin
    if (!RST) begin
      tck_bits = tck_status;
      assert (seen_mask[tck_bits]) else begin
        other_errs++;
        $display("tck_status showed %h, a value the CPU status never held", tck_bits);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin : main
    logic [31:0] r_kind;
    logic [31:0] r_adr;
    logic [31:0] r_dat;
    CLKA       = 1'b0;
    CLKB       = 1'b0;
    RST        = 1'b1;
    wb_req     = '0;
    cpu_bp     = 1'b0;
    m_ctrl     = 2'd0;
    m_bp       = 1'b0;
    pend_wr    = 1'b0;
    pend_adr   = 2'd0;
    pend_dat   = 32'd0;
    // Register B reset value
    seen_mask  = 16'h0001;
    tck_bits   = 4'd0;
    lfsr_q     = 16'd93;
    val_errs   = 0;
    other_errs = 0;
    repeat (RST_CYC) @(posedge CLKA);
    @(negedge CLKA);
    RST = 1'b0;
    // First status after reset must reach the tap side by itself
    check_crossing(XFER_CYC);
    for (int n = 0; n < NUM_ACC; n++) begin
      r_kind = take_bits(1);
      r_adr  = take_bits(2);
      r_dat  = take_bits(32);
      access(r_kind[0], r_adr[1:0], r_dat, 1'b0);
      idle(int'(take_bits(1)), 1'b1);
      if (n % 50 == 49) begin
        check_crossing(SETTLE_CYC);
      end
    end
    // A clear and a breakpoint on the same edge leave the flag set
    access(1'b1, REG_CTRL, 32'd0, 1'b0);
    access(1'b1, REG_BPCLR, 32'd1, 1'b1);
    access(1'b0, REG_STATUS, 32'd0, 1'b0);
    check_crossing(SETTLE_CYC);
    $display("Summary: %0d value errors, %0d other errors", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: run did not end within %0d ns", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
